/* include/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define DATA_BITS     32
`define OP_CODE_BITS  6
`define REG_ADDR_BITS 5
`define MEM_ADDR_BITS 8

`define OP_CODE_NOP   6'b000000

// register alu ops, group 00.
`define OP_CODE_ADD   6'b000001
`define OP_CODE_SUB   6'b000010
`define OP_CODE_NOT   6'b000011
`define OP_CODE_AND   6'b000100
`define OP_CODE_OR    6'b000101
`define OP_CODE_NAND  6'b000110
`define OP_CODE_NOR   6'b000111
`define OP_CODE_MOV   6'b001000
`define OP_CODE_SAR   6'b001001
`define OP_CODE_SHR   6'b001010
`define OP_CODE_SHL   6'b001011
`define OP_CODE_XOR   6'b001100
`define OP_CODE_TEST  6'b001101
`define OP_CODE_CMP   6'b001110

// immediate forms, same low bits in group 01.
`define OP_CODE_ADDI  6'b010001
`define OP_CODE_SUBI  6'b010010
`define OP_CODE_NOTI  6'b010011
`define OP_CODE_ANDI  6'b010100
`define OP_CODE_ORI   6'b010101
`define OP_CODE_NANDI 6'b010110
`define OP_CODE_NORI  6'b010111
`define OP_CODE_MOVI  6'b011000
`define OP_CODE_SARI  6'b011001
`define OP_CODE_SHRI  6'b011010
`define OP_CODE_SHLI  6'b011011
`define OP_CODE_XORI  6'b011100
`define OP_CODE_TESTI 6'b011101
`define OP_CODE_CMPI  6'b011110

// memory, group 10.
`define OP_CODE_LW    6'b100000
`define OP_CODE_LA    6'b100001
`define OP_CODE_SW    6'b100010
`define OP_CODE_SA    6'b100011

// jumps, group 11.
`define OP_CODE_JMP   6'b110000
`define OP_CODE_JE    6'b110001
`define OP_CODE_JNE   6'b110010
`define OP_CODE_JL    6'b110011
`define OP_CODE_JLE   6'b110100
`define OP_CODE_JG    6'b110101
`define OP_CODE_JGE   6'b110110
`define OP_CODE_JZ    6'b110111
`define OP_CODE_JNZ   6'b111000
`define OP_CODE_JO    6'b111001
`define OP_CODE_JR    6'b111010

`endif

/* source/cpu_pkg.sv */
package cpu_pkg;

  // order matches the low opcode bits of the alu groups.
  typedef enum logic [3:0] {
    ALU_OP_NOP, ALU_OP_ADD, ALU_OP_SUB, ALU_OP_NOT,
    ALU_OP_AND, ALU_OP_OR, ALU_OP_NAND, ALU_OP_NOR,
    ALU_OP_MOV, ALU_OP_SAR, ALU_OP_SHR, ALU_OP_SHL,
    ALU_OP_XOR, ALU_OP_TEST, ALU_OP_CMP
  } alu_op_t;

  typedef enum logic [1:0] {
    MEM_OP_NOP, MEM_OP_READ, MEM_OP_WRITE
  } mem_op_t;

  typedef enum logic [3:0] {
    JMP_OP_NOP, JMP_OP_J, JMP_OP_JEQ, JMP_OP_JNE,
    JMP_OP_JL, JMP_OP_JLE, JMP_OP_JG, JMP_OP_JGE,
    JMP_OP_JZ, JMP_OP_JNZ, JMP_OP_JO, JMP_OP_JR
  } jmp_op_t;

  typedef struct packed {
    logic zero;
    logic sign;
    logic overflow;
  } flags_t;

endpackage

/* source/instr_decode.sv */
`include "cpu_params.svh"

module instr_decode (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      instr_valid,
  input  logic [`DATA_BITS-1:0]     instr,
  output logic                      exec,
  output logic [`OP_CODE_BITS-1:0]  opcode,
  output logic [`REG_ADDR_BITS-1:0] rs,
  output logic [`REG_ADDR_BITS-1:0] rt,
  output logic [`REG_ADDR_BITS-1:0] rd,
  output logic [`DATA_BITS-1:0]     imm
);

  logic [`DATA_BITS-1:0] instr_q; // held word.

  always_ff @(posedge clk) begin
    if (reset) begin
      exec <= 1'b0;
    end else begin
      exec <= instr_valid; // one exec cycle per strobe.
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid) begin
      instr_q <= instr;
    end
  end

  assign opcode = instr_q[31:26];
  assign rs     = instr_q[25:21];
  assign rt     = instr_q[20:16];
  assign rd     = instr_q[15:11];
  assign imm    = {{(`DATA_BITS-16){instr_q[15]}}, instr_q[15:0]}; // sign-extended.

endmodule

/* source/control_unit.sv */
`include "cpu_params.svh"

module control_unit (
  input  logic [`OP_CODE_BITS-1:0] opcode,
  output logic                     reg_dst,
  output logic                     alu_src,
  output logic                     mem_to_reg,
  output logic                     reg_write,
  output logic                     address_src,
  output cpu_pkg::alu_op_t         alu_op,
  output cpu_pkg::mem_op_t         mem_op,
  output cpu_pkg::jmp_op_t         jop
);

  import cpu_pkg::*;

  always_comb begin
    reg_dst     = 1'b0;
    alu_src     = 1'b0;
    mem_to_reg  = 1'b0;
    reg_write   = 1'b0;
    address_src = 1'b0;
    alu_op      = ALU_OP_NOP;
    mem_op      = MEM_OP_NOP;
    jop         = JMP_OP_NOP;

    // coarse decode on the group bits.
    case (opcode[5:4])
      2'b00: begin
        if (opcode != `OP_CODE_NOP) begin
          reg_dst   = 1'b1; // writes rd.
          reg_write = (opcode != `OP_CODE_CMP) && (opcode != `OP_CODE_TEST);
        end
      end
      2'b01: begin
        alu_src   = 1'b1; // immediate operand, writes rt.
        reg_write = (opcode != `OP_CODE_CMPI) && (opcode != `OP_CODE_TESTI);
      end
      2'b10: alu_src = 1'b1; // offset comes from imm.
      default: ;
    endcase

    // per opcode refinement.
    case (opcode)
      `OP_CODE_ADD,  `OP_CODE_ADDI:  alu_op = ALU_OP_ADD;
      `OP_CODE_SUB,  `OP_CODE_SUBI:  alu_op = ALU_OP_SUB;
      `OP_CODE_NOT,  `OP_CODE_NOTI:  alu_op = ALU_OP_NOT;
      `OP_CODE_AND,  `OP_CODE_ANDI:  alu_op = ALU_OP_AND;
      `OP_CODE_OR,   `OP_CODE_ORI:   alu_op = ALU_OP_OR;
      `OP_CODE_NAND, `OP_CODE_NANDI: alu_op = ALU_OP_NAND;
      `OP_CODE_NOR,  `OP_CODE_NORI:  alu_op = ALU_OP_NOR;
      `OP_CODE_MOV,  `OP_CODE_MOVI:  alu_op = ALU_OP_MOV;
      `OP_CODE_SAR,  `OP_CODE_SARI:  alu_op = ALU_OP_SAR;
      `OP_CODE_SHR,  `OP_CODE_SHRI:  alu_op = ALU_OP_SHR;
      `OP_CODE_SHL,  `OP_CODE_SHLI:  alu_op = ALU_OP_SHL;
      `OP_CODE_XOR,  `OP_CODE_XORI:  alu_op = ALU_OP_XOR;
      `OP_CODE_TEST, `OP_CODE_TESTI: alu_op = ALU_OP_TEST;
      `OP_CODE_CMP,  `OP_CODE_CMPI:  alu_op = ALU_OP_CMP;
      `OP_CODE_LW, `OP_CODE_LA: begin
        alu_op      = (opcode == `OP_CODE_LW) ? ALU_OP_ADD : ALU_OP_NOP;
        address_src = (opcode == `OP_CODE_LA); // absolute address.
        mem_to_reg  = 1'b1;
        reg_write   = 1'b1;
        mem_op      = MEM_OP_READ;
      end
      `OP_CODE_SW, `OP_CODE_SA: begin
        alu_op      = (opcode == `OP_CODE_SW) ? ALU_OP_ADD : ALU_OP_NOP;
        address_src = (opcode == `OP_CODE_SA);
        mem_op      = MEM_OP_WRITE;
      end
      `OP_CODE_JMP: jop = JMP_OP_J;
      `OP_CODE_JE:  jop = JMP_OP_JEQ;
      `OP_CODE_JNE: jop = JMP_OP_JNE;
      `OP_CODE_JL:  jop = JMP_OP_JL;
      `OP_CODE_JLE: jop = JMP_OP_JLE;
      `OP_CODE_JG:  jop = JMP_OP_JG;
      `OP_CODE_JGE: jop = JMP_OP_JGE;
      `OP_CODE_JZ:  jop = JMP_OP_JZ;
      `OP_CODE_JNZ: jop = JMP_OP_JNZ;
      `OP_CODE_JO:  jop = JMP_OP_JO;
      `OP_CODE_JR:  jop = JMP_OP_JR;
      default: ;
    endcase
  end

endmodule

/* source/register_file.sv */
`include "cpu_params.svh"

module register_file (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [`REG_ADDR_BITS-1:0] rs,
  input  logic [`REG_ADDR_BITS-1:0] rt,
  output logic [`DATA_BITS-1:0]     rs_data,
  output logic [`DATA_BITS-1:0]     rt_data,
  input  logic                      write_enable,
  input  logic [`REG_ADDR_BITS-1:0] write_reg,
  input  logic [`DATA_BITS-1:0]     write_data
);

  logic [`DATA_BITS-1:0] regs [2**`REG_ADDR_BITS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**`REG_ADDR_BITS; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable) begin
      regs[write_reg] <= write_data; // r0 is writable too.
    end
  end

  assign rs_data = regs[rs];
  assign rt_data = regs[rt];

endmodule

/* source/alu.sv */
`include "cpu_params.svh"

module alu (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  exec,
  input  cpu_pkg::alu_op_t      alu_op,
  input  logic [`DATA_BITS-1:0] operand_a,
  input  logic [`DATA_BITS-1:0] operand_b,
  output logic [`DATA_BITS-1:0] result,
  output cpu_pkg::flags_t       flags
);

  import cpu_pkg::*;

  localparam int msb = `DATA_BITS - 1;

  logic   [4:0] shamt;
  flags_t       next_flags;

  assign shamt = operand_b[4:0]; // low 5 bits only.

  always_comb begin
    case (alu_op)
      ALU_OP_ADD:               result = operand_a + operand_b;
      ALU_OP_SUB, ALU_OP_CMP:   result = operand_a - operand_b;
      ALU_OP_NOT:               result = ~operand_a;
      ALU_OP_AND, ALU_OP_TEST:  result = operand_a & operand_b;
      ALU_OP_OR:                result = operand_a | operand_b;
      ALU_OP_NAND:              result = ~(operand_a & operand_b);
      ALU_OP_NOR:               result = ~(operand_a | operand_b);
      ALU_OP_XOR:               result = operand_a ^ operand_b;
      ALU_OP_MOV:               result = operand_b;
      ALU_OP_SAR:               result = $signed(operand_a) >>> shamt;
      ALU_OP_SHR:               result = operand_a >> shamt;
      ALU_OP_SHL:               result = operand_a << shamt;
      default:                  result = '0;
    endcase
  end

  always_comb begin
    next_flags.zero = (result == '0);
    next_flags.sign = result[msb];
    case (alu_op)
      // same operand signs, result sign flipped.
      ALU_OP_ADD: next_flags.overflow = (operand_a[msb] == operand_b[msb]) &&
                                        (result[msb] != operand_a[msb]);
      ALU_OP_SUB, ALU_OP_CMP:
        next_flags.overflow = (operand_a[msb] != operand_b[msb]) &&
                              (result[msb] != operand_a[msb]);
      default: next_flags.overflow = 1'b0;
    endcase
  end

  // mov and nop leave the flags alone.
  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else if (exec && alu_op != ALU_OP_NOP && alu_op != ALU_OP_MOV) begin
      flags <= next_flags;
    end
  end

endmodule

/* source/branch_unit.sv */
`include "cpu_params.svh"

module branch_unit (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  exec,
  input  cpu_pkg::jmp_op_t      jop,
  input  cpu_pkg::flags_t       flags,
  input  logic [`DATA_BITS-1:0] imm,
  input  logic [`DATA_BITS-1:0] rs_data,
  output logic [`DATA_BITS-1:0] pc
);

  import cpu_pkg::*;

  logic                  taken;
  logic                  less; // signed less than.
  logic [`DATA_BITS-1:0] target;

  assign less   = flags.sign ^ flags.overflow;
  assign target = (jop == JMP_OP_JR) ? rs_data : imm;

  // flags here are still the ones from before this instruction.
  always_comb begin
    case (jop)
      JMP_OP_J, JMP_OP_JR:     taken = 1'b1;
      JMP_OP_JEQ, JMP_OP_JZ:   taken = flags.zero;
      JMP_OP_JNE, JMP_OP_JNZ:  taken = !flags.zero;
      JMP_OP_JL:               taken = less;
      JMP_OP_JLE:              taken = flags.zero || less;
      JMP_OP_JG:               taken = !flags.zero && !less;
      JMP_OP_JGE:              taken = !less;
      JMP_OP_JO:               taken = flags.overflow;
      default:                 taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (exec) begin
      pc <= taken ? target : pc + 1'b1;
    end
  end

endmodule

/* source/data_memory.sv */
`include "cpu_params.svh"

module data_memory (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  exec,
  input  cpu_pkg::mem_op_t      mem_op,
  input  logic                  mem_to_reg,
  input  logic                  address_src,
  input  logic [`DATA_BITS-1:0] alu_result,
  input  logic [`DATA_BITS-1:0] imm,
  input  logic [`DATA_BITS-1:0] store_data,
  output logic [`DATA_BITS-1:0] wb_data
);

  import cpu_pkg::*;

  logic [`DATA_BITS-1:0]     mem [2**`MEM_ADDR_BITS];
  logic [`MEM_ADDR_BITS-1:0] addr;

  // upper address bits dropped, so it wraps at the depth.
  assign addr = address_src ? imm[`MEM_ADDR_BITS-1:0] : alu_result[`MEM_ADDR_BITS-1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**`MEM_ADDR_BITS; i++) begin
        mem[i] <= '0;
      end
    end else if (exec && mem_op == MEM_OP_WRITE) begin
      mem[addr] <= store_data;
    end
  end

  assign wb_data = mem_to_reg ? mem[addr] : alu_result; // load or alu value.

endmodule

/* source/cpu_core.sv */
`include "cpu_params.svh"

module cpu_core (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      instr_valid,
  input  logic [`DATA_BITS-1:0]     instr,
  output logic [`DATA_BITS-1:0]     pc,
  output logic                      wb_valid,
  output logic [`REG_ADDR_BITS-1:0] wb_reg,
  output logic [`DATA_BITS-1:0]     wb_data
);

  import cpu_pkg::*;

  logic                      exec;
  logic [`OP_CODE_BITS-1:0]  opcode;
  logic [`REG_ADDR_BITS-1:0] rs;
  logic [`REG_ADDR_BITS-1:0] rt;
  logic [`REG_ADDR_BITS-1:0] rd;
  logic [`DATA_BITS-1:0]     imm;
  logic                      reg_dst;
  logic                      alu_src;
  logic                      mem_to_reg;
  logic                      reg_write;
  logic                      address_src;
  alu_op_t                   alu_op;
  mem_op_t                   mem_op;
  jmp_op_t                   jop;
  logic [`DATA_BITS-1:0]     rs_data;
  logic [`DATA_BITS-1:0]     rt_data;
  logic [`DATA_BITS-1:0]     operand_b;
  logic [`DATA_BITS-1:0]     alu_result;
  flags_t                    flags;

  assign wb_valid  = exec && reg_write;
  assign wb_reg    = reg_dst ? rd : rt;
  assign operand_b = alu_src ? imm : rt_data; // imm for i-type and memory ops.

  instr_decode instr_decode_i (
    .clk, .reset, .instr_valid, .instr,
    .exec, .opcode, .rs, .rt, .rd, .imm
  );

  control_unit control_unit_i (
    .opcode, .reg_dst, .alu_src, .mem_to_reg, .reg_write,
    .address_src, .alu_op, .mem_op, .jop
  );

  register_file register_file_i (
    .clk, .reset, .rs, .rt, .rs_data, .rt_data,
    .write_enable (wb_valid),
    .write_reg    (wb_reg),
    .write_data   (wb_data)
  );

  alu alu_i (
    .clk, .reset, .exec, .alu_op,
    .operand_a (rs_data),
    .operand_b (operand_b),
    .result    (alu_result),
    .flags     (flags)
  );

  branch_unit branch_unit_i (
    .clk, .reset, .exec, .jop, .flags, .imm, .rs_data, .pc
  );

  data_memory data_memory_i (
    .clk, .reset, .exec, .mem_op, .mem_to_reg, .address_src,
    .alu_result, .imm,
    .store_data (rt_data),
    .wb_data    (wb_data)
  );

endmodule

/* tests/cpu_core_tb.sv */
`include "cpu_params.svh"

module cpu_core_tb;

  localparam int clk_period  = 100;
  localparam int reps        = 4;
  localparam int burst_len   = 24;
  // instructions issued by all tests together.
  localparam int total_instr = 1 + 14*reps*5 + 14*reps*3 + reps*10 + 11*reps*6 + 6 + burst_len;

  logic                      clk;
  logic                      reset;
  logic                      instr_valid;
  logic [`DATA_BITS-1:0]     instr;
  logic [`DATA_BITS-1:0]     pc;
  logic                      wb_valid;
  logic [`REG_ADDR_BITS-1:0] wb_reg;
  logic [`DATA_BITS-1:0]     wb_data;

  // expected outputs for the current exec cycle.
  logic                      exp_valid;
  logic [`REG_ADDR_BITS-1:0] exp_reg;
  logic [`DATA_BITS-1:0]     exp_data;
  logic [`DATA_BITS-1:0]     exp_pc;

  // reference model state.
  logic [`DATA_BITS-1:0] m_regs [2**`REG_ADDR_BITS];
  logic [`DATA_BITS-1:0] m_mem [2**`MEM_ADDR_BITS];
  logic                  m_zero, m_sign, m_ovf;
  logic [`DATA_BITS-1:0] m_pc;
  logic                  pend; // an instruction is in its exec cycle.
  logic [`DATA_BITS-1:0] pend_word;

  int seed = 32'hee4d294d;
  int errors, instr_count, test_count, errors_at_start;

  cpu_core cpu_core_i (
    .clk, .reset, .instr_valid, .instr, .pc, .wb_valid, .wb_reg, .wb_data
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period/2) clk = ~clk;
  end

  check_wb_valid: assert property (@(posedge clk) disable iff (reset) wb_valid == exp_valid)
    else begin
      errors++;
      $display("error %0t: wb_valid %b, expected %b", $time, $sampled(wb_valid),
               $sampled(exp_valid));
    end

  check_wb_value: assert property (@(posedge clk) disable iff (reset)
                                   exp_valid |-> (wb_reg == exp_reg && wb_data == exp_data))
    else begin
      errors++;
      $display("error %0t: wrote r%0d = %h, expected r%0d = %h", $time, $sampled(wb_reg),
               $sampled(wb_data), $sampled(exp_reg), $sampled(exp_data));
    end

  check_pc: assert property (@(posedge clk) disable iff (reset) pc == exp_pc)
    else begin
      errors++;
      $display("error %0t: pc %h, expected %h", $time, $sampled(pc), $sampled(exp_pc));
    end

  initial begin
    #((total_instr * 4 + 10 + 10) * clk_period);
    $display("watchdog expired before the tests finished");
    $display("Checks failed");
    $finish;
  end

  function automatic logic [4:0] rand_reg();
    return 5'($random(seed));
  endfunction

  function automatic logic [15:0] rand16();
    return 16'($random(seed));
  endfunction

  function automatic logic [31:0] r_type(input logic [5:0] op, input logic [4:0] rs, rt, rd);
    return {op, rs, rt, rd, 11'd0};
  endfunction

  function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs, rt,
                                         input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // {overflow, result} for the alu kind in the low opcode bits.
  function automatic logic [32:0] alu_model(input logic [3:0] kind, input logic [31:0] a, b);
    logic [31:0] r;
    logic        v;
    r = '0;
    v = 1'b0;
    case (kind)
      4'd1: begin
        r = a + b;
        v = (a[31] == b[31]) && (r[31] != a[31]);
      end
      4'd2, 4'd14: begin
        r = a - b;
        v = (a[31] != b[31]) && (r[31] != a[31]);
      end
      4'd3: r = ~a;
      4'd4, 4'd13: r = a & b;
      4'd5: r = a | b;
      4'd6: r = ~(a & b);
      4'd7: r = ~(a | b);
      4'd8: r = b;
      4'd9: r = $signed(a) >>> b[4:0];
      4'd10: r = a >> b[4:0];
      4'd11: r = a << b[4:0];
      4'd12: r = a ^ b;
      default: r = '0;
    endcase
    return {v, r};
  endfunction

  function automatic logic jump_model(input logic [5:0] op, input logic z, s, o);
    case (op)
      `OP_CODE_JMP, `OP_CODE_JR: return 1'b1;
      `OP_CODE_JE, `OP_CODE_JZ:  return z;
      `OP_CODE_JNE, `OP_CODE_JNZ: return !z;
      `OP_CODE_JL:  return s != o;
      `OP_CODE_JLE: return z || (s != o);
      `OP_CODE_JG:  return !z && (s == o);
      `OP_CODE_JGE: return s == o;
      `OP_CODE_JO:  return o;
      default: return 1'b0;
    endcase
  endfunction

  task automatic set_flags(input logic [32:0] res);
    m_zero = (res[31:0] == '0);
    m_sign = res[31];
    m_ovf  = res[32];
  endtask

  // executes one word on the model and sets the expected outputs.
  task automatic model_exec(input logic [31:0] word);
    logic [5:0]                op;
    logic [4:0]                rs, rt, rd;
    logic [31:0]               imm, b;
    logic [32:0]               res;
    logic [`MEM_ADDR_BITS-1:0] addr;
    op  = word[31:26];
    rs  = word[25:21];
    rt  = word[20:16];
    rd  = word[15:11];
    imm = {{16{word[15]}}, word[15:0]};
    exp_valid = 1'b0;
    exp_reg   = '0;
    exp_data  = '0;
    case (op[5:4])
      2'b00, 2'b01: if (op != `OP_CODE_NOP) begin
        b   = op[4] ? imm : m_regs[rt];
        res = alu_model(op[3:0], m_regs[rs], b);
        if (op[3:0] != 4'd8) set_flags(res); // mov keeps flags.
        if (op[3:0] != 4'd13 && op[3:0] != 4'd14) begin
          exp_valid = 1'b1;
          exp_reg   = op[4] ? rt : rd;
          exp_data  = res[31:0];
        end
      end
      2'b10: begin
        res = alu_model(4'd1, m_regs[rs], imm);
        if (op[0]) begin
          addr = imm[`MEM_ADDR_BITS-1:0]; // absolute.
        end else begin
          addr = res[`MEM_ADDR_BITS-1:0];
          set_flags(res); // offset add goes through the alu.
        end
        if (op[1]) begin
          m_mem[addr] = m_regs[rt];
        end else begin
          exp_valid = 1'b1;
          exp_reg   = rt;
          exp_data  = m_mem[addr];
        end
      end
      default: ;
    endcase
    if (op[5:4] == 2'b11 && jump_model(op, m_zero, m_sign, m_ovf)) begin
      m_pc = (op == `OP_CODE_JR) ? m_regs[rs] : imm;
    end else begin
      m_pc = m_pc + 32'd1;
    end
    if (exp_valid) m_regs[exp_reg] = exp_data;
  endtask

  // one clock cycle of stimulus, driven on the falling edge.
  task automatic step(input logic valid, input logic [31:0] word);
    @(negedge clk);
    exp_pc = m_pc;
    if (pend) model_exec(pend_word);
    else exp_valid = 1'b0;
    instr_valid = valid;
    instr       = word;
    pend        = valid;
    pend_word   = word;
    if (valid) instr_count++;
  endtask

  task automatic issue(input logic [31:0] word);
    step(1'b1, word);
    step(1'b0, '0);
  endtask

  task automatic seed_reg(input logic [4:0] r);
    issue(i_type(`OP_CODE_MOVI, 5'd0, r, rand16()));
    issue(i_type(`OP_CODE_SHLI, r, r, 16'({$random(seed)} % 17)));
  endtask

  task automatic finish_test(input string name);
    step(1'b0, '0); // lets the last check fire.
    test_count++;
    $display("test %0d %s: %0d errors", test_count, name, errors - errors_at_start);
    errors_at_start = errors;
  endtask

  initial begin
    logic [4:0]  rs, rt, rd, rt2;
    logic [4:0]  last_dst;
    logic [15:0] imm;
    logic [5:0]  op;
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    exp_valid   = 1'b0;
    exp_reg     = '0;
    exp_data    = '0;
    exp_pc      = '0;
    pend        = 1'b0;
    pend_word   = '0;
    m_pc        = '0;
    m_zero      = 1'b0;
    m_sign      = 1'b0;
    m_ovf       = 1'b0;
    errors          = 0;
    instr_count     = 0;
    test_count      = 0;
    errors_at_start = 0;
    for (int i = 0; i < 2**`REG_ADDR_BITS; i++) m_regs[i] = '0;
    for (int i = 0; i < 2**`MEM_ADDR_BITS; i++) m_mem[i] = '0;
    repeat (10) @(negedge clk);
    reset = 1'b0;

    repeat (3) step(1'b0, '0); // idle, no writeback expected.
    issue(r_type(`OP_CODE_NOP, rand_reg(), rand_reg(), rand_reg()));
    finish_test("reset and nop");

    for (int k = 1; k <= 14; k++) begin
      for (int n = 0; n < reps; n++) begin
        rs = rand_reg();
        rt = rand_reg();
        rd = rand_reg();
        seed_reg(rs);
        seed_reg(rt);
        issue(r_type(6'(k), rs, rt, rd));
      end
    end
    finish_test("register alu ops");

    for (int k = 1; k <= 14; k++) begin
      for (int n = 0; n < reps; n++) begin
        rs = rand_reg();
        seed_reg(rs);
        issue(i_type(6'(16 + k), rs, rand_reg(), rand16()));
      end
    end
    finish_test("immediate alu ops");

    for (int n = 0; n < reps; n++) begin
      rs  = rand_reg();
      rt  = rand_reg();
      rt2 = rand_reg();
      imm = rand16();
      seed_reg(rs);
      seed_reg(rt);
      issue(i_type(`OP_CODE_SW, rs, rt, imm));
      issue(i_type(`OP_CODE_LW, rs, rt2, imm));
      rt  = rand_reg();
      imm = rand16();
      seed_reg(rt);
      issue(i_type(`OP_CODE_SA, rand_reg(), rt, imm));
      issue(i_type(`OP_CODE_LA, rand_reg(), rand_reg(), imm));
    end
    finish_test("loads and stores");

    for (int j = 0; j < 11; j++) begin
      op = `OP_CODE_JMP + 6'(j);
      for (int n = 0; n < reps; n++) begin
        rs = rand_reg();
        rt = rand_reg();
        seed_reg(rs);
        seed_reg(rt);
        if ({$random(seed)} % 4 == 0) rt = rs; // equal operands now and then.
        issue(r_type(($random(seed) & 1) ? `OP_CODE_CMP : `OP_CODE_TEST, rs, rt, 5'd0));
        issue(i_type(op, rs, 5'd0, rand16()));
      end
    end
    finish_test("jumps");

    seed_reg(5'd1);
    seed_reg(5'd2);
    seed_reg(5'd3);
    last_dst = 5'd3;
    for (int n = 0; n < burst_len; n++) begin
      op = 6'(1 + {$random(seed)} % 14);
      rs = last_dst; // operand a is the previous result.
      rt = 5'(1 + {$random(seed)} % 3);
      rd = 5'(1 + {$random(seed)} % 3);
      if ($random(seed) & 1) begin
        step(1'b1, i_type(op | 6'b010000, rs, rt, rand16()));
        if (op != `OP_CODE_TEST && op != `OP_CODE_CMP) last_dst = rt;
      end else begin
        step(1'b1, r_type(op, rs, rt, rd));
        if (op != `OP_CODE_TEST && op != `OP_CODE_CMP) last_dst = rd;
      end
    end
    step(1'b0, '0);
    finish_test("back to back");

    repeat (2) step(1'b0, '0);
    $display("%0d tests, %0d instructions, %0d errors", test_count, instr_count, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+include
source/cpu_pkg.sv
source/instr_decode.sv
source/control_unit.sv
source/register_file.sv
source/alu.sv
source/branch_unit.sv
source/data_memory.sv
source/cpu_core.sv
tests/cpu_core_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal -f sources.f --top-module cpu_core_tb -o cpu_core_sim \
  && ./obj_dir/cpu_core_sim | tee /dev/stderr | grep -q "All checks passed" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
